// ==== design/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath and pc width
`define RV_XLEN 64
// instruction word width
`define RV_ILEN 32
// register index width
`define RV_REG_ID_W 5
// number of architectural registers
`define RV_NUM_REGS 32

// first fetch address after reset
`define RV_RESET_PC 64'h0000_0000_8000_0000
// sequential pc increment
`define RV_PC_STEP 64'd4

// major opcodes
`define RV_OPC_OP 7'b0110011
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_LUI 7'b0110111
`define RV_OPC_AUIPC 7'b0010111
`define RV_OPC_SYSTEM 7'b1110011

// funct fields for add/sub/addi
`define RV_F3_ADD_SUB 3'b000
`define RV_F7_ADD 7'b0000000
`define RV_F7_SUB 7'b0100000

// whole ebreak word, no operand bits
`define RV_EBREAK 32'h0010_0073

`endif

// ==== design/rv_pkg.sv ====
`include "rv_consts.svh"

package rv_pkg;

  // r-type view: register-register ops
  typedef struct packed {
    logic [6:0]                  funct7;
    logic [`RV_REG_ID_W-1:0]     rs2;
    logic [`RV_REG_ID_W-1:0]     rs1;
    logic [2:0]                  funct3;
    logic [`RV_REG_ID_W-1:0]     rd;
    logic [6:0]                  opcode;
  } r_fmt_t;

  // i-type view: 12-bit immediate in the top bits
  typedef struct packed {
    logic [11:0]                 imm12;
    logic [`RV_REG_ID_W-1:0]     rs1;
    logic [2:0]                  funct3;
    logic [`RV_REG_ID_W-1:0]     rd;
    logic [6:0]                  opcode;
  } i_fmt_t;

  // u-type view: upper 20 bits of a 32-bit constant
  typedef struct packed {
    logic [19:0]                 imm20;
    logic [`RV_REG_ID_W-1:0]     rd;
    logic [6:0]                  opcode;
  } u_fmt_t;

  // one instruction word, read through whichever format the opcode says
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    u_fmt_t u;
  } inst_t;

  // alu operations needed by add/sub/addi/lui/auipc
  typedef enum logic [1:0] {
    alu_add    = 2'd0,
    alu_sub    = 2'd1,
    alu_pass_b = 2'd2
  } alu_op_e;

  // everything execute needs from one decoded word
  typedef struct packed {
    logic [`RV_REG_ID_W-1:0]     rd;
    logic [`RV_REG_ID_W-1:0]     rs1;
    logic [`RV_REG_ID_W-1:0]     rs2;
    logic [`RV_XLEN-1:0]         imm;
    alu_op_e                     alu_op;
    // operand 2 from imm instead of rs2
    logic                        use_imm;
    // operand 1 from pc instead of rs1
    logic                        use_pc;
    logic                        reg_write;
    logic                        is_ebreak;
    logic                        illegal;
  } decode_t;

  // write-back request, also seen at the top as the commit port
  typedef struct packed {
    logic                        valid;
    logic [`RV_REG_ID_W-1:0]     rd;
    logic [`RV_XLEN-1:0]         data;
  } commit_t;

endpackage

// ==== design/pc_gen.sv ====
`timescale 1ns/1ps

`include "rv_consts.svh"

module pc_gen (
  input  logic                clk,
  input  logic                reset,
  input  logic                is_ebreak,
  output logic [`RV_XLEN-1:0] current_pc,
  output logic [`RV_XLEN-1:0] next_pc,
  output logic                halted
);

  // pc freezes on the ebreak itself and every cycle after
  logic hold_pc;

  assign hold_pc = halted || is_ebreak;

  // sequential fetch only, no branches or jumps
  always_comb begin
    if (hold_pc) begin
      next_pc = current_pc;
    end else begin
      next_pc = current_pc + `RV_PC_STEP;
    end
  end

  // pc register
  always_ff @(posedge clk) begin
    if (reset) begin
      current_pc <= `RV_RESET_PC;
    end else begin
      current_pc <= next_pc;
    end
  end

  // halt latch, only reset clears it
  always_ff @(posedge clk) begin
    if (reset) begin
      halted <= 1'b0;
    end else if (is_ebreak) begin
      halted <= 1'b1;
    end
  end

  // reset pc and +4 steps keep the pc word aligned
  pc_aligned_a: assert property (
    @(posedge clk) disable iff (reset) current_pc[1:0] == 2'b00
  );

endmodule

// ==== design/inst_decoder.sv ====
`timescale 1ns/1ps

`include "rv_consts.svh"

module inst_decoder (
  input  rv_pkg::inst_t   inst,
  output rv_pkg::decode_t dec
);

  // sign-extended immediates for both immediate formats
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_u;

  // i-type: 12 bits, sign from bit 31
  assign imm_i = {{(`RV_XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};

  // u-type: imm20 in bits 31:12, low 12 zero, then sign-extend to 64
  assign imm_u = {{(`RV_XLEN-32){inst.u.imm20[19]}}, inst.u.imm20, 12'b0};

  always_comb begin
    // register fields sit at the same place in every format
    dec           = '0;
    dec.rd        = inst.r.rd;
    dec.rs1       = inst.r.rs1;
    dec.rs2       = inst.r.rs2;
    dec.alu_op    = rv_pkg::alu_add;
    // assume illegal until a pattern matches
    dec.illegal   = 1'b1;

    case (inst.r.opcode)
      // add / sub
      `RV_OPC_OP: begin
        if (inst.r.funct3 == `RV_F3_ADD_SUB) begin
          if (inst.r.funct7 == `RV_F7_ADD) begin
            dec.alu_op    = rv_pkg::alu_add;
            dec.reg_write = 1'b1;
            dec.illegal   = 1'b0;
          end else if (inst.r.funct7 == `RV_F7_SUB) begin
            dec.alu_op    = rv_pkg::alu_sub;
            dec.reg_write = 1'b1;
            dec.illegal   = 1'b0;
          end
        end
      end

      // addi only, other op-imm functs are not supported
      `RV_OPC_OP_IMM: begin
        if (inst.i.funct3 == `RV_F3_ADD_SUB) begin
          dec.imm       = imm_i;
          dec.use_imm   = 1'b1;
          dec.alu_op    = rv_pkg::alu_add;
          dec.reg_write = 1'b1;
          dec.illegal   = 1'b0;
        end
      end

      // lui passes the shifted immediate straight through
      `RV_OPC_LUI: begin
        dec.imm       = imm_u;
        dec.use_imm   = 1'b1;
        dec.alu_op    = rv_pkg::alu_pass_b;
        dec.reg_write = 1'b1;
        dec.illegal   = 1'b0;
      end

      // auipc: pc + shifted immediate
      `RV_OPC_AUIPC: begin
        dec.imm       = imm_u;
        dec.use_imm   = 1'b1;
        dec.use_pc    = 1'b1;
        dec.alu_op    = rv_pkg::alu_add;
        dec.reg_write = 1'b1;
        dec.illegal   = 1'b0;
      end

      // system space: only the exact ebreak word is accepted
      `RV_OPC_SYSTEM: begin
        if (inst == `RV_EBREAK) begin
          dec.is_ebreak = 1'b1;
          dec.illegal   = 1'b0;
        end
      end

      // unknown opcode, illegal stays set and nothing is written
      default: begin
        dec.reg_write = 1'b0;
      end
    endcase
  end

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/1ps

`include "rv_consts.svh"

module register_file (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`RV_REG_ID_W-1:0] rs1,
  input  logic [`RV_REG_ID_W-1:0] rs2,
  input  rv_pkg::commit_t         wb,
  output logic [`RV_XLEN-1:0]     rdata_1,
  output logic [`RV_XLEN-1:0]     rdata_2
);

  // x1..x31, x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  // write on the edge, reset clears every register
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // combinational reads, no bypass
  // same-cycle write to the read index shows the old value
  always_comb begin
    if (rs1 == '0) begin
      rdata_1 = '0;
    end else begin
      rdata_1 = regs[rs1];
    end
  end

  always_comb begin
    if (rs2 == '0) begin
      rdata_2 = '0;
    end else begin
      rdata_2 = regs[rs2];
    end
  end

  // execute never requests a write to x0
  x0_stays_zero_a: assert property (
    @(posedge clk) disable iff (reset)
    (wb.rd == '0) |-> !wb.valid
  );

endmodule

// ==== design/execute_unit.sv ====
`timescale 1ns/1ps

`include "rv_consts.svh"

module execute_unit (
  input  logic                reset,
  input  rv_pkg::decode_t     dec,
  input  logic [`RV_XLEN-1:0] rdata_1,
  input  logic [`RV_XLEN-1:0] rdata_2,
  input  logic [`RV_XLEN-1:0] current_pc,
  input  logic                halted,
  output rv_pkg::commit_t     wb
);

  logic [`RV_XLEN-1:0] operand_1;
  logic [`RV_XLEN-1:0] operand_2;
  logic [`RV_XLEN-1:0] result;

  // pc for auipc, otherwise rs1
  assign operand_1 = dec.use_pc ? current_pc : rdata_1;
  // immediate or rs2
  assign operand_2 = dec.use_imm ? dec.imm : rdata_2;

  // 64-bit wraparound arithmetic
  always_comb begin
    case (dec.alu_op)
      rv_pkg::alu_sub:    result = operand_1 - operand_2;
      rv_pkg::alu_pass_b: result = operand_2;
      default:            result = operand_1 + operand_2;
    endcase
  end

  // no commit in reset, after halt, or for x0
  assign wb.valid = dec.reg_write && !halted && !reset && (dec.rd != '0);
  assign wb.rd    = dec.rd;
  assign wb.data  = result;

endmodule

// ==== design/rv_core.sv ====
`timescale 1ns/1ps

`include "rv_consts.svh"

module rv_core (
  input  logic                clk,
  input  logic                reset,
  input  rv_pkg::inst_t       inst,
  output logic [`RV_XLEN-1:0] current_pc,
  output logic [`RV_XLEN-1:0] next_pc,
  output rv_pkg::commit_t     commit,
  output logic                illegal,
  output logic                halted
);

  // decode result, shared by regfile and execute
  rv_pkg::decode_t     dec;

  // register read data
  logic [`RV_XLEN-1:0] rdata_1;
  logic [`RV_XLEN-1:0] rdata_2;

  // write-back request from execute
  rv_pkg::commit_t     wb;

  // pc register and halt latch
  pc_gen u_pc_gen (
    .clk        ( clk           ),
    .reset      ( reset         ),
    .is_ebreak  ( dec.is_ebreak ),
    .current_pc ( current_pc    ),
    .next_pc    ( next_pc       ),
    .halted     ( halted        )
  );

  // same-cycle decode of the presented word
  inst_decoder u_inst_decoder (
    .inst ( inst ),
    .dec  ( dec  )
  );

  // read in this cycle, write back on the next edge
  register_file u_register_file (
    .clk     ( clk     ),
    .reset   ( reset   ),
    .rs1     ( dec.rs1 ),
    .rs2     ( dec.rs2 ),
    .wb      ( wb      ),
    .rdata_1 ( rdata_1 ),
    .rdata_2 ( rdata_2 )
  );

  // alu and write-enable gating
  execute_unit u_execute_unit (
    .reset      ( reset      ),
    .dec        ( dec        ),
    .rdata_1    ( rdata_1    ),
    .rdata_2    ( rdata_2    ),
    .current_pc ( current_pc ),
    .halted     ( halted     ),
    .wb         ( wb         )
  );

  // write-back is visible at the boundary in the same cycle
  assign commit  = wb;
  assign illegal = dec.illegal;

  // ebreak must shut off write-back from the very next cycle on
  no_commit_after_ebreak_a: assert property (
    @(posedge clk) disable iff (reset) dec.is_ebreak |=> !commit.valid
  );

endmodule

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/1ps

`include "rv_consts.svh"

module rv_core_tb;

  // one row of stimulus and expected response
  typedef struct packed {
    logic [`RV_ILEN-1:0]     inst;
    logic                    valid;
    logic [`RV_REG_ID_W-1:0] rd;
    logic [`RV_XLEN-1:0]     data;
    logic                    illegal;
    logic [`RV_XLEN-1:0]     pc;
    logic [`RV_XLEN-1:0]     next_pc;
    logic                    halted;
  } vector_t;

  localparam int reset_timeout = 40;

  logic                clk;
  logic                reset;
  rv_pkg::inst_t       inst;
  logic [`RV_XLEN-1:0] current_pc;
  logic [`RV_XLEN-1:0] next_pc;
  rv_pkg::commit_t     commit;
  logic                illegal;
  logic                halted;

  vector_t             vectors[$];
  int                  error_count;
  int                  check_count;
  integer              seed;
  // running pc and halt state while the table is built
  logic [`RV_XLEN-1:0] pc_model;
  logic                halt_model;

  rv_core rv_core_inst (
    .clk        ( clk        ),
    .reset      ( reset      ),
    .inst       ( inst       ),
    .current_pc ( current_pc ),
    .next_pc    ( next_pc    ),
    .commit     ( commit     ),
    .illegal    ( illegal    ),
    .halted     ( halted     )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
  end

  // instruction encoders
  function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, `RV_F3_ADD_SUB, rd, `RV_OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] r_type_word(input logic [6:0] funct7, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [4:0] rs2);
    return {funct7, rs2, rs1, `RV_F3_ADD_SUB, rd, `RV_OPC_OP};
  endfunction

  function automatic logic [31:0] u_type_word(input logic [6:0] opcode, input logic [4:0] rd,
                                              input logic [19:0] imm20);
    return {imm20, rd, opcode};
  endfunction

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAIL @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // appends a row; pc, next_pc and halted follow the sequential fetch rule
  task automatic add_entry(input logic [31:0] word, input logic valid, input logic [4:0] rd,
                           input logic [63:0] data, input logic ill, input logic stops);
    vector_t v;
    v.inst    = word;
    v.valid   = valid;
    v.rd      = rd;
    v.data    = data;
    v.illegal = ill;
    v.pc      = pc_model;
    v.next_pc = (halt_model || stops) ? pc_model : pc_model + 64'd4;
    v.halted  = halt_model;
    vectors.push_back(v);
    pc_model   = v.next_pc;
    halt_model = halt_model || stops;
  endtask

  task automatic build_vectors();
    logic [31:0] rnd;
    logic [11:0] imm;
    logic [63:0] acc;
    logic [4:0]  src;
    // first entry follows the addi consumed at the reset pc
    pc_model   = `RV_RESET_PC + 64'd4;
    halt_model = 1'b0;
    // addi / add / sub chain, x2 read right after its write
    add_entry(addi_word(5'd1, 5'd0, 12'd5), 1'b1, 5'd1, 64'd5, 1'b0, 1'b0);
    add_entry(addi_word(5'd2, 5'd0, 12'hffd), 1'b1, 5'd2, 64'hffff_ffff_ffff_fffd, 1'b0, 1'b0);
    add_entry(r_type_word(`RV_F7_ADD, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, 64'd2, 1'b0, 1'b0);
    add_entry(r_type_word(`RV_F7_SUB, 5'd4, 5'd2, 5'd1), 1'b1, 5'd4,
              64'hffff_ffff_ffff_fff8, 1'b0, 1'b0);
    add_entry(r_type_word(`RV_F7_SUB, 5'd5, 5'd0, 5'd1), 1'b1, 5'd5,
              64'hffff_ffff_ffff_fffb, 1'b0, 1'b0);
    // all ones plus one wraps to zero
    add_entry(addi_word(5'd9, 5'd0, 12'hfff), 1'b1, 5'd9, 64'hffff_ffff_ffff_ffff, 1'b0, 1'b0);
    add_entry(addi_word(5'd10, 5'd9, 12'd1), 1'b1, 5'd10, 64'd0, 1'b0, 1'b0);
    // lui, positive and sign-extended
    add_entry(u_type_word(`RV_OPC_LUI, 5'd7, 20'h12345), 1'b1, 5'd7, 64'h1234_5000, 1'b0, 1'b0);
    add_entry(u_type_word(`RV_OPC_LUI, 5'd8, 20'h80000), 1'b1, 5'd8,
              64'hffff_ffff_8000_0000, 1'b0, 1'b0);
    add_entry(r_type_word(`RV_F7_ADD, 5'd6, 5'd8, 5'd8), 1'b1, 5'd6,
              64'hffff_ffff_0000_0000, 1'b0, 1'b0);
    // auipc relative to this row's pc
    add_entry(u_type_word(`RV_OPC_AUIPC, 5'd11, 20'h00001), 1'b1, 5'd11,
              pc_model + 64'h1000, 1'b0, 1'b0);
    add_entry(u_type_word(`RV_OPC_AUIPC, 5'd12, 20'hfffff), 1'b1, 5'd12,
              pc_model - 64'h1000, 1'b0, 1'b0);
    // x0 target gives no commit, x0 source gives the other operand
    add_entry(addi_word(5'd0, 5'd1, 12'd7), 1'b0, 5'd0, 64'd0, 1'b0, 1'b0);
    add_entry(r_type_word(`RV_F7_ADD, 5'd13, 5'd0, 5'd3), 1'b1, 5'd13, 64'd2, 1'b0, 1'b0);
    add_entry(r_type_word(`RV_F7_ADD, 5'd17, 5'd3, 5'd0), 1'b1, 5'd17, 64'd2, 1'b0, 1'b0);
    // unknown opcode and an unsupported funct7
    add_entry(32'hffff_ffff, 1'b0, 5'd0, 64'd0, 1'b1, 1'b0);
    add_entry(r_type_word(7'b0000001, 5'd18, 5'd1, 5'd1), 1'b0, 5'd0, 64'd0, 1'b1, 1'b0);
    // random addi chain starting from x1
    acc = 64'd5;
    src = 5'd1;
    for (int k = 0; k < 3; k++) begin
      rnd = $random(seed);
      imm = rnd[11:0];
      acc = acc + {{52{imm[11]}}, imm};
      add_entry(addi_word(5'(14 + k), src, imm), 1'b1, 5'(14 + k), acc, 1'b0, 1'b0);
      src = 5'(14 + k);
    end
    // ebreak, then valid words that must not commit
    add_entry(`RV_EBREAK, 1'b0, 5'd0, 64'd0, 1'b0, 1'b1);
    add_entry(addi_word(5'd1, 5'd0, 12'd1), 1'b0, 5'd0, 64'd0, 1'b0, 1'b0);
    add_entry(addi_word(5'd20, 5'd1, 12'd9), 1'b0, 5'd0, 64'd0, 1'b0, 1'b0);
    add_entry(u_type_word(`RV_OPC_LUI, 5'd21, 20'h00abc), 1'b0, 5'd0, 64'd0, 1'b0, 1'b0);
  endtask

  initial begin
    int   wait_cycles;
    logic timed_out;
    error_count = 0;
    check_count = 0;
    wait_cycles = 0;
    timed_out   = 1'b0;
    seed        = 32'ha16a_dc56;
    // addi x1, x1, 1 held through reset, a real write that reset must gate off
    inst        = addi_word(5'd1, 5'd1, 12'd1);
    build_vectors();

    // commit must stay quiet for the whole reset
    while (reset && !timed_out) begin
      @(negedge clk);
      if (reset) begin
        check_value("commit.valid in reset", 64'(commit.valid), 64'd0);
      end
      wait_cycles++;
      if (reset && wait_cycles >= reset_timeout) begin
        timed_out = 1'b1;
      end
    end

    if (!timed_out) begin
      // first cycle out of reset, addi presented
      check_value("current_pc after reset", current_pc, `RV_RESET_PC);
      check_value("next_pc after reset", next_pc, `RV_RESET_PC + 64'd4);
      check_value("halted after reset", 64'(halted), 64'd0);
      // x1 was cleared by reset, so the sum is just the immediate
      check_value("commit.valid after reset", 64'(commit.valid), 64'd1);
      check_value("commit.rd after reset", 64'(commit.rd), 64'd1);
      check_value("commit.data after reset", commit.data, 64'd1);

      foreach (vectors[i]) begin
        @(posedge clk);
        inst <= vectors[i].inst;
        // outputs settle well before the falling edge
        @(negedge clk);
        check_value($sformatf("row %0d current_pc", i), current_pc, vectors[i].pc);
        check_value($sformatf("row %0d next_pc", i), next_pc, vectors[i].next_pc);
        check_value($sformatf("row %0d halted", i), 64'(halted), 64'(vectors[i].halted));
        check_value($sformatf("row %0d illegal", i), 64'(illegal), 64'(vectors[i].illegal));
        check_value($sformatf("row %0d commit.valid", i), 64'(commit.valid),
                    64'(vectors[i].valid));
        if (vectors[i].valid) begin
          check_value($sformatf("row %0d commit.rd", i), 64'(commit.rd), 64'(vectors[i].rd));
          check_value($sformatf("row %0d commit.data", i), commit.data, vectors[i].data);
        end
      end
    end

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      if (timed_out) begin
        $display("reset was still high after %0d cycles", reset_timeout);
      end
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+design
design/rv_pkg.sv
design/pc_gen.sv
design/inst_decoder.sv
design/register_file.sv
design/execute_unit.sv
design/rv_core.sv
verification/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the rv_core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module rv_core_tb -f files.f -o rv_core_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/rv_core_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints the pass line only when every check held
if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
  echo "result: pass"
  exit 0
else
  echo "result: fail"
  exit 1
fi
